// ==== hw/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    localparam int NUM_STREAMS = 4;
    localparam int REQ_LINES   = 4;
    localparam int DATA_W      = 32;
    localparam int STREAM_W    = 2;
    localparam int NDT_W       = 16;
    localparam int PL_W        = 2;
    localparam int CHSEL_W     = $clog2(REQ_LINES);

    // offsets inside one stream block
    localparam logic [3:0] REG_CR   = 4'h0;
    localparam logic [3:0] REG_NDTR = 4'h4;
    localparam logic [3:0] REG_PAR  = 4'h8;
    localparam logic [3:0] REG_MAR  = 4'hc;

    localparam int         STREAM_STRIDE = 'h10;
    localparam logic [7:0] REG_ISR       = 8'h40;

    // control register fields
    localparam int CR_EN    = 0;
    localparam int CR_DIR   = 1;
    localparam int CR_PINC  = 2;
    localparam int CR_MINC  = 3;
    localparam int CR_CHSEL = 4;
    localparam int CR_PL    = 6;
    localparam int CR_TCIE  = 8;
    localparam int CR_TEIE  = 9;
    localparam int CR_W     = 10;

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [2:0] HSIZE_WORD    = 3'b010;

    typedef struct packed {
        logic              en;
        logic              dir;
        logic              pinc;
        logic              minc;
        logic [PL_W-1:0]   pl;
        logic [DATA_W-1:0] par;
        logic [DATA_W-1:0] mar;
        logic [NDT_W-1:0]  ndtr;
    } stream_cfg_t;

endpackage

`default_nettype wire

// ==== hw/dma_reg_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dma_reg_bus_if;

    logic [dma_pkg::DATA_W-1:0] addr;
    logic                       wr_en;
    logic                       rd_en;
    logic [dma_pkg::DATA_W-1:0] wdata;
    logic [dma_pkg::DATA_W-1:0] rdata;

    modport slave (output addr, output wr_en, output rd_en, output wdata, input rdata);

    modport regs (input addr, input wr_en, input rd_en, input wdata, output rdata);

endinterface

`default_nettype wire

// ==== hw/dma_xfer_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dma_xfer_if;

    logic                       req;
    logic                       write;
    logic [dma_pkg::DATA_W-1:0] addr;
    logic [dma_pkg::DATA_W-1:0] wdata;
    logic [dma_pkg::DATA_W-1:0] rdata;
    logic                       done;
    logic                       err;

    modport seq (output req, output write, output addr, output wdata,
                 input rdata, input done, input err);

    modport master (input req, input write, input addr, input wdata,
                    output rdata, output done, output err);

endinterface

`default_nettype wire

// ==== hw/dma_slave_ahb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_slave_ahb (
    input  logic                       i_hclk,
    input  logic                       i_rst_n,

    input  logic                       i_hsel,
    input  logic [dma_pkg::DATA_W-1:0] i_haddr,
    input  logic                       i_hwrite,
    input  logic [1:0]                 i_htrans,
    input  logic                       i_hready,
    input  logic [dma_pkg::DATA_W-1:0] i_hwdata,
    output logic                       o_hreadyout,
    output logic                       o_hresp,
    output logic [dma_pkg::DATA_W-1:0] o_hrdata,

    dma_reg_bus_if.slave               bus
);

logic                       addr_valid;
logic                       dph_wr;
logic                       dph_rd;
logic [dma_pkg::DATA_W-1:0] dph_addr;

// NONSEQ or SEQ, both have htrans[1] set
assign addr_valid = i_hsel && i_hready && i_htrans[1];

always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        dph_wr <= 1'b0;
        dph_rd <= 1'b0;
    end else if (i_hready) begin
        dph_wr <= addr_valid && i_hwrite;
        dph_rd <= addr_valid && !i_hwrite;
    end
end

always_ff @(posedge i_hclk) begin
    if (addr_valid) begin
        dph_addr <= i_haddr;
    end
end

// strobes live in the data phase, write data arrives there too
assign bus.addr  = dph_addr;
assign bus.wr_en = dph_wr;
assign bus.rd_en = dph_rd;
assign bus.wdata = i_hwdata;

// register file never stalls and never errors
assign o_hreadyout = 1'b1;
assign o_hresp     = 1'b0;
assign o_hrdata    = bus.rdata;

endmodule

`default_nettype wire

// ==== hw/dma_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
    input  logic                                   i_hclk,
    input  logic                                   i_rst_n,

    dma_reg_bus_if.regs                            bus,

    input  logic [dma_pkg::NUM_STREAMS*dma_pkg::REQ_LINES-1:0] i_req,
    output dma_pkg::stream_cfg_t                   o_cfg[dma_pkg::NUM_STREAMS-1:0],
    output logic [dma_pkg::NUM_STREAMS-1:0]        o_req_sel,

    input  logic                                   i_step,
    input  logic                                   i_fail,
    input  logic [dma_pkg::STREAM_W-1:0]           i_stream,

    output logic [dma_pkg::NUM_STREAMS-1:0]        o_interrupt
);

logic [dma_pkg::CR_W-1:0]        cr[dma_pkg::NUM_STREAMS-1:0];
logic [dma_pkg::NDT_W-1:0]       ndtr[dma_pkg::NUM_STREAMS-1:0];
logic [dma_pkg::DATA_W-1:0]      par[dma_pkg::NUM_STREAMS-1:0];
logic [dma_pkg::DATA_W-1:0]      mar[dma_pkg::NUM_STREAMS-1:0];
logic [2*dma_pkg::NUM_STREAMS-1:0] isr;
logic [2*dma_pkg::NUM_STREAMS-1:0] isr_set;
logic [2*dma_pkg::NUM_STREAMS-1:0] isr_clr;

logic                            is_isr;
logic                            in_stream;
logic [dma_pkg::STREAM_W-1:0]    sel;
logic [3:0]                      ofs;
logic [dma_pkg::DATA_W-1:0]      rd_mux;
logic                            last_word;

// address map decode
assign is_isr    = bus.addr[7:0] == dma_pkg::REG_ISR;
assign in_stream = bus.addr[7:0] < dma_pkg::REG_ISR;
assign sel       = bus.addr[$clog2(dma_pkg::STREAM_STRIDE) +: dma_pkg::STREAM_W];
assign ofs       = bus.addr[3:0];

assign last_word = ndtr[i_stream] == dma_pkg::NDT_W'(1);

always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        for (int s = 0; s < dma_pkg::NUM_STREAMS; s++) begin
            cr[s]   <= '0;
            ndtr[s] <= '0;
            par[s]  <= '0;
            mar[s]  <= '0;
        end
    end else begin
        if (i_step) begin
            ndtr[i_stream] <= ndtr[i_stream] - 1'b1;
            if (cr[i_stream][dma_pkg::CR_PINC]) begin
                par[i_stream] <= par[i_stream] + dma_pkg::DATA_W'(4);
            end
            if (cr[i_stream][dma_pkg::CR_MINC]) begin
                mar[i_stream] <= mar[i_stream] + dma_pkg::DATA_W'(4);
            end
            if (last_word) begin
                cr[i_stream][dma_pkg::CR_EN] <= 1'b0;
            end
        end
        if (i_fail) begin
            cr[i_stream][dma_pkg::CR_EN] <= 1'b0;
        end
        // bus write comes last so it overrides a step to the same register
        if (bus.wr_en && in_stream) begin
            case (ofs)
                dma_pkg::REG_CR:   cr[sel]   <= bus.wdata[dma_pkg::CR_W-1:0];
                dma_pkg::REG_NDTR: ndtr[sel] <= bus.wdata[dma_pkg::NDT_W-1:0];
                dma_pkg::REG_PAR:  par[sel]  <= bus.wdata;
                dma_pkg::REG_MAR:  mar[sel]  <= bus.wdata;
                default: ;
            endcase
        end
    end
end

// tcif at bit 2s, teif at bit 2s+1
always_comb begin
    isr_set = '0;
    isr_clr = '0;
    if (i_step && last_word) begin
        isr_set[{i_stream, 1'b0}] = 1'b1;
    end
    if (i_fail) begin
        isr_set[{i_stream, 1'b1}] = 1'b1;
    end
    if (bus.wr_en && is_isr) begin
        isr_clr = bus.wdata[2*dma_pkg::NUM_STREAMS-1:0];
    end
end

// a new event beats a clear in the same cycle
always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        isr <= '0;
    end else begin
        isr <= (isr & ~isr_clr) | isr_set;
    end
end

always_comb begin
    rd_mux = '0;
    if (is_isr) begin
        rd_mux = dma_pkg::DATA_W'(isr);
    end else if (in_stream) begin
        case (ofs)
            dma_pkg::REG_CR:   rd_mux = dma_pkg::DATA_W'(cr[sel]);
            dma_pkg::REG_NDTR: rd_mux = dma_pkg::DATA_W'(ndtr[sel]);
            dma_pkg::REG_PAR:  rd_mux = par[sel];
            dma_pkg::REG_MAR:  rd_mux = mar[sel];
            default:           rd_mux = '0;
        endcase
    end
end

assign bus.rdata = bus.rd_en ? rd_mux : '0;

always_comb begin
    for (int s = 0; s < dma_pkg::NUM_STREAMS; s++) begin
        o_cfg[s].en   = cr[s][dma_pkg::CR_EN];
        o_cfg[s].dir  = cr[s][dma_pkg::CR_DIR];
        o_cfg[s].pinc = cr[s][dma_pkg::CR_PINC];
        o_cfg[s].minc = cr[s][dma_pkg::CR_MINC];
        o_cfg[s].pl   = cr[s][dma_pkg::CR_PL +: dma_pkg::PL_W];
        o_cfg[s].par  = par[s];
        o_cfg[s].mar  = mar[s];
        o_cfg[s].ndtr = ndtr[s];
        // pick one of the stream's request lines
        o_req_sel[s] = i_req[s*dma_pkg::REQ_LINES +
                             cr[s][dma_pkg::CR_CHSEL +: dma_pkg::CHSEL_W]];
        o_interrupt[s] = (isr[2*s] & cr[s][dma_pkg::CR_TCIE]) |
                         (isr[2*s+1] & cr[s][dma_pkg::CR_TEIE]);
    end
end

endmodule

`default_nettype wire

// ==== hw/dma_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_arbiter (
    input  logic                            i_hclk,
    input  logic                            i_rst_n,

    input  dma_pkg::stream_cfg_t            i_cfg[dma_pkg::NUM_STREAMS-1:0],
    input  logic [dma_pkg::NUM_STREAMS-1:0] i_req_sel,
    input  logic                            i_busy,

    output logic                            o_grant,
    output logic [dma_pkg::STREAM_W-1:0]    o_stream
);

logic [dma_pkg::NUM_STREAMS-1:0] elig;
logic                            found;
logic [dma_pkg::STREAM_W-1:0]    best;
logic [dma_pkg::PL_W-1:0]        best_pl;

// walk down so the lower index takes ties
always_comb begin
    found   = 1'b0;
    best    = '0;
    best_pl = '0;
    for (int s = dma_pkg::NUM_STREAMS - 1; s >= 0; s--) begin
        elig[s] = i_cfg[s].en && (i_cfg[s].ndtr != '0) && i_req_sel[s];
        if (elig[s] && (!found || i_cfg[s].pl >= best_pl)) begin
            found   = 1'b1;
            best    = dma_pkg::STREAM_W'(s);
            best_pl = i_cfg[s].pl;
        end
    end
end

// one-cycle grant, the sequencer turns busy right after
always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_grant  <= 1'b0;
        o_stream <= '0;
    end else begin
        o_grant <= !i_busy && !o_grant && found;
        if (!i_busy && !o_grant && found) begin
            o_stream <= best;
        end
    end
end

endmodule

`default_nettype wire

// ==== hw/dma_stream_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_stream_seq (
    input  logic                         i_hclk,
    input  logic                         i_rst_n,

    input  dma_pkg::stream_cfg_t         i_cfg[dma_pkg::NUM_STREAMS-1:0],
    input  logic                         i_grant,
    input  logic [dma_pkg::STREAM_W-1:0] i_stream,
    output logic                         o_busy,

    dma_xfer_if.seq                      xfer,

    output logic                         o_step,
    output logic                         o_fail,
    output logic [dma_pkg::STREAM_W-1:0] o_stream
);

typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WRITE,
    S_DONE
} state_t;

state_t                       state;
dma_pkg::stream_cfg_t         cfg_g;
logic [dma_pkg::STREAM_W-1:0] stream_q;
logic                         req_q;
logic                         write_q;
logic                         step_q;
logic                         fail_q;
logic [dma_pkg::DATA_W-1:0]   addr_q;
logic [dma_pkg::DATA_W-1:0]   dst_addr;
logic [dma_pkg::DATA_W-1:0]   buf_q;

assign cfg_g = i_cfg[i_stream];

always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        state    <= S_IDLE;
        stream_q <= '0;
        req_q    <= 1'b0;
        write_q  <= 1'b0;
        step_q   <= 1'b0;
        fail_q   <= 1'b0;
    end else begin
        step_q <= 1'b0;
        fail_q <= 1'b0;
        case (state)
            S_IDLE: begin
                if (i_grant) begin
                    stream_q <= i_stream;
                    write_q  <= 1'b0;
                    req_q    <= 1'b1;
                    state    <= S_READ;
                end
            end
            S_READ: begin
                if (xfer.done) begin
                    req_q <= 1'b0;
                    if (xfer.err) begin
                        fail_q <= 1'b1;
                        state  <= S_DONE;
                    end else begin
                        write_q <= 1'b1;
                        state   <= S_WRITE;
                    end
                end
            end
            S_WRITE: begin
                // req stays low for one cycle between the two requests
                if (!req_q) begin
                    req_q <= 1'b1;
                end else if (xfer.done) begin
                    req_q  <= 1'b0;
                    step_q <= !xfer.err;
                    fail_q <= xfer.err;
                    state  <= S_DONE;
                end
            end
            default: begin
                state <= S_IDLE;
            end
        endcase
    end
end

// source by direction, par for periph-to-mem
always_ff @(posedge i_hclk) begin
    if (state == S_IDLE && i_grant) begin
        addr_q   <= cfg_g.dir ? cfg_g.mar : cfg_g.par;
        dst_addr <= cfg_g.dir ? cfg_g.par : cfg_g.mar;
    end else if (state == S_READ && xfer.done) begin
        addr_q <= dst_addr;
        buf_q  <= xfer.rdata;
    end
end

assign xfer.req   = req_q;
assign xfer.write = write_q;
assign xfer.addr  = addr_q;
assign xfer.wdata = buf_q;

assign o_busy   = state != S_IDLE;
assign o_step   = step_q;
assign o_fail   = fail_q;
assign o_stream = stream_q;

endmodule

`default_nettype wire

// ==== hw/dma_master_ahb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_master_ahb (
    input  logic                       i_hclk,
    input  logic                       i_rst_n,

    dma_xfer_if.master                 xfer,

    output logic [dma_pkg::DATA_W-1:0] o_haddr,
    output logic                       o_hwrite,
    output logic [1:0]                 o_htrans,
    output logic [2:0]                 o_hsize,
    output logic [dma_pkg::DATA_W-1:0] o_hwdata,
    input  logic                       i_hready,
    input  logic                       i_hresp,
    input  logic [dma_pkg::DATA_W-1:0] i_hrdata
);

typedef enum logic [1:0] {
    M_IDLE,
    M_ADDR,
    M_DATA
} mstate_t;

mstate_t state;

always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        state <= M_IDLE;
    end else begin
        case (state)
            M_IDLE: begin
                if (xfer.req) begin
                    state <= M_ADDR;
                end
            end
            // address accepted once the previous data phase is over
            M_ADDR: begin
                if (i_hready) begin
                    state <= M_DATA;
                end
            end
            M_DATA: begin
                if (i_hready) begin
                    state <= M_IDLE;
                end
            end
            default: begin
                state <= M_IDLE;
            end
        endcase
    end
end

assign o_htrans = (state == M_ADDR) ? dma_pkg::HTRANS_NONSEQ : dma_pkg::HTRANS_IDLE;
assign o_haddr  = xfer.addr;
assign o_hwrite = xfer.write;
assign o_hsize  = dma_pkg::HSIZE_WORD;

// sequencer holds wdata until done, so a stall keeps it stable
assign o_hwdata = xfer.wdata;

assign xfer.done  = (state == M_DATA) && i_hready;
assign xfer.err   = (state == M_DATA) && i_hready && i_hresp;
assign xfer.rdata = i_hrdata;

endmodule

`default_nettype wire

// ==== hw/dma_ahb_s4ch4.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_ahb_s4ch4 (
    input  logic                       i_hclk,
    input  logic                       i_rst_n,

    // configuration slave
    input  logic                       i_s_hsel,
    input  logic [dma_pkg::DATA_W-1:0] i_s_haddr,
    input  logic                       i_s_hwrite,
    input  logic [1:0]                 i_s_htrans,
    input  logic                       i_s_hready,
    input  logic [dma_pkg::DATA_W-1:0] i_s_hwdata,
    output logic                       o_s_hreadyout,
    output logic                       o_s_hresp,
    output logic [dma_pkg::DATA_W-1:0] o_s_hrdata,

    // transfer master
    output logic [dma_pkg::DATA_W-1:0] o_m_haddr,
    output logic                       o_m_hwrite,
    output logic [1:0]                 o_m_htrans,
    output logic [2:0]                 o_m_hsize,
    output logic [dma_pkg::DATA_W-1:0] o_m_hwdata,
    input  logic                       i_m_hready,
    input  logic                       i_m_hresp,
    input  logic [dma_pkg::DATA_W-1:0] i_m_hrdata,

    input  logic [dma_pkg::NUM_STREAMS*dma_pkg::REQ_LINES-1:0] i_req,
    output logic [dma_pkg::NUM_STREAMS-1:0] o_interrupt
);

dma_pkg::stream_cfg_t            cfg[dma_pkg::NUM_STREAMS-1:0];
logic [dma_pkg::NUM_STREAMS-1:0] req_sel;
logic                            grant;
logic [dma_pkg::STREAM_W-1:0]    grant_stream;
logic                            busy;
logic                            step;
logic                            fail;
logic [dma_pkg::STREAM_W-1:0]    seq_stream;

dma_reg_bus_if reg_bus ();
dma_xfer_if    xfer ();

dma_slave_ahb u_slave (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .i_hsel      (i_s_hsel),
    .i_haddr     (i_s_haddr),
    .i_hwrite    (i_s_hwrite),
    .i_htrans    (i_s_htrans),
    .i_hready    (i_s_hready),
    .i_hwdata    (i_s_hwdata),
    .o_hreadyout (o_s_hreadyout),
    .o_hresp     (o_s_hresp),
    .o_hrdata    (o_s_hrdata),
    .bus         (reg_bus.slave)
);

dma_regs u_regs (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .bus         (reg_bus.regs),
    .i_req       (i_req),
    .o_cfg       (cfg),
    .o_req_sel   (req_sel),
    .i_step      (step),
    .i_fail      (fail),
    .i_stream    (seq_stream),
    .o_interrupt (o_interrupt)
);

dma_arbiter u_arbiter (
    .i_hclk    (i_hclk),
    .i_rst_n   (i_rst_n),
    .i_cfg     (cfg),
    .i_req_sel (req_sel),
    .i_busy    (busy),
    .o_grant   (grant),
    .o_stream  (grant_stream)
);

dma_stream_seq u_seq (
    .i_hclk   (i_hclk),
    .i_rst_n  (i_rst_n),
    .i_cfg    (cfg),
    .i_grant  (grant),
    .i_stream (grant_stream),
    .o_busy   (busy),
    .xfer     (xfer.seq),
    .o_step   (step),
    .o_fail   (fail),
    .o_stream (seq_stream)
);

dma_master_ahb u_master (
    .i_hclk   (i_hclk),
    .i_rst_n  (i_rst_n),
    .xfer     (xfer.master),
    .o_haddr  (o_m_haddr),
    .o_hwrite (o_m_hwrite),
    .o_htrans (o_m_htrans),
    .o_hsize  (o_m_hsize),
    .o_hwdata (o_m_hwdata),
    .i_hready (i_m_hready),
    .i_hresp  (i_m_hresp),
    .i_hrdata (i_m_hrdata)
);

endmodule

`default_nettype wire

// ==== testbench/tb_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dma;

localparam logic [31:0] SEED       = 32'hfb40c2f6;
localparam int          NCASE      = 7;
localparam int          CASE_WORDS = 20;
localparam int          TIMEOUT    = 200;

// word positions inside one case
localparam int F_STREAM = 0;
localparam int F_DIR    = 1;
localparam int F_PINC   = 2;
localparam int F_MINC   = 3;
localparam int F_PL     = 4;
localparam int F_CHSEL  = 5;
localparam int F_TCIE   = 6;
localparam int F_TEIE   = 7;
localparam int F_PAR    = 8;
localparam int F_MAR    = 9;
localparam int F_NDTR   = 10;
localparam int F_ISR    = 11;
localparam int F_SRC    = 12;
localparam int F_DST    = 16;

logic        clk;
logic        rst_n;
logic        s_hsel;
logic [31:0] s_haddr;
logic        s_hwrite;
logic [1:0]  s_htrans;
logic        s_hready;
logic [31:0] s_hwdata;
logic        s_hreadyout;
logic        s_hresp;
logic [31:0] s_hrdata;
logic [31:0] m_haddr;
logic        m_hwrite;
logic [1:0]  m_htrans;
logic [2:0]  m_hsize;
logic [31:0] m_hwdata;
logic        m_hready;
logic        m_hresp;
logic [31:0] m_hrdata;
logic [15:0] req;
logic [3:0]  irq;

logic [31:0] golden[NCASE*CASE_WORDS];
logic [31:0] mem[256];
logic [31:0] wr_log[$];
int          errors;
int          timeouts;

// memory model state
logic        dph_busy  = 1'b0;
logic        dph_write = 1'b0;
logic        dph_err   = 1'b0;
logic [31:0] dph_addr  = 32'h0;
int          wait_left = 0;

dma_ahb_s4ch4 dma_ahb_s4ch4_i (
    .i_hclk        (clk),
    .i_rst_n       (rst_n),
    .i_s_hsel      (s_hsel),
    .i_s_haddr     (s_haddr),
    .i_s_hwrite    (s_hwrite),
    .i_s_htrans    (s_htrans),
    .i_s_hready    (s_hready),
    .i_s_hwdata    (s_hwdata),
    .o_s_hreadyout (s_hreadyout),
    .o_s_hresp     (s_hresp),
    .o_s_hrdata    (s_hrdata),
    .o_m_haddr     (m_haddr),
    .o_m_hwrite    (m_hwrite),
    .o_m_htrans    (m_htrans),
    .o_m_hsize     (m_hsize),
    .o_m_hwdata    (m_hwdata),
    .i_m_hready    (m_hready),
    .i_m_hresp     (m_hresp),
    .i_m_hrdata    (m_hrdata),
    .i_req         (req),
    .o_interrupt   (irq)
);

always #4 clk = ~clk;

// slave model on the master port with 0 to 2 wait states and a two-cycle error above 0x7ff
always @(posedge clk) begin
    if (dph_busy && m_hready) begin
        if (dph_write && !dph_err) begin
            mem[dph_addr[9:2]] = m_hwdata;
            wr_log.push_back(dph_addr);
        end
        dph_busy = 1'b0;
    end
    if (m_hready && m_htrans == 2'b10) begin
        if (m_hsize !== 3'b010) begin
            $display("Fail o_m_hsize: got %h, expected %h", m_hsize, 3'b010);
            errors++;
        end
        dph_busy  = 1'b1;
        dph_addr  = m_haddr;
        dph_write = m_hwrite;
        dph_err   = m_haddr >= 32'h800;
        wait_left = dph_err ? 1 : int'($urandom % 3);
    end
    if (dph_busy && wait_left > 0) begin
        m_hready  <= 1'b0;
        m_hresp   <= dph_err;
        wait_left = wait_left - 1;
    end else begin
        m_hready <= 1'b1;
        m_hresp  <= dph_busy && dph_err;
        m_hrdata <= (dph_busy && !dph_write) ? mem[dph_addr[9:2]] : 32'h0;
    end
end

function automatic logic [31:0] gw(input int c, input int k);
    return golden[c*CASE_WORDS + k];
endfunction

function automatic int req_bit(input int c);
    return int'(gw(c, F_STREAM)) * 4 + int'(gw(c, F_CHSEL));
endfunction

function automatic logic [3:0] stream_bit(input int c);
    return 4'h1 << gw(c, F_STREAM);
endfunction

function automatic logic [31:0] dest_addr(input int c);
    return (gw(c, F_DIR) != 0) ? gw(c, F_PAR) : gw(c, F_MAR);
endfunction

// higher pl first and the lower stream index on a tie
function automatic int pick_first(input int a, input int b);
    if (gw(a, F_PL) > gw(b, F_PL)) begin
        return a;
    end
    if (gw(b, F_PL) > gw(a, F_PL)) begin
        return b;
    end
    return (gw(a, F_STREAM) < gw(b, F_STREAM)) ? a : b;
endfunction

function automatic string reg_name(input int r);
    case (r)
        0:       return "CR";
        1:       return "NDTR";
        2:       return "PAR";
        default: return "MAR";
    endcase
endfunction

function automatic logic [31:0] reg_mask(input int r);
    case (r)
        0:       return 32'h3fe;
        1:       return 32'hffff;
        default: return 32'hffffffff;
    endcase
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Fail %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    s_hsel   <= 1'b1;
    s_haddr  <= addr;
    s_hwrite <= 1'b1;
    s_htrans <= 2'b10;
    @(posedge clk);
    s_hsel   <= 1'b0;
    s_htrans <= 2'b00;
    s_hwdata <= data;
    @(posedge clk);
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    s_hsel   <= 1'b1;
    s_haddr  <= addr;
    s_hwrite <= 1'b0;
    s_htrans <= 2'b10;
    @(posedge clk);
    s_hsel   <= 1'b0;
    s_htrans <= 2'b00;
    // middle of the data phase
    @(negedge clk);
    data = s_hrdata;
    check_value("o_s_hreadyout", 32'(s_hreadyout), 32'h1);
    check_value("o_s_hresp", 32'(s_hresp), 32'h0);
endtask

// poll the status register until every listed stream shows a flag
task automatic wait_flags(input logic [3:0] streams);
    logic [31:0] isr;
    logic        hit;
    int          n;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < TIMEOUT) begin
        bus_read(32'(dma_pkg::REG_ISR), isr);
        hit = 1'b1;
        for (int s = 0; s < 4; s++) begin
            if (streams[s] && isr[2*s +: 2] == 2'b00) begin
                hit = 1'b0;
            end
        end
        n++;
    end
    if (!hit) begin
        $display("Timeout: streams %b never raised a status flag", streams);
        timeouts++;
    end
endtask

task automatic test_registers();
    logic [31:0] got;
    logic [31:0] addr;
    logic [31:0] val[4][4];
    for (int s = 0; s < 4; s++) begin
        for (int r = 0; r < 4; r++) begin
            addr = s * dma_pkg::STREAM_STRIDE + r * 4;
            bus_read(addr, got);
            check_value($sformatf("%s%0d after reset", reg_name(r), s), got, 32'h0);
        end
    end
    bus_read(32'(dma_pkg::REG_ISR), got);
    check_value("ISR after reset", got, 32'h0);
    for (int s = 0; s < 4; s++) begin
        for (int r = 0; r < 4; r++) begin
            val[s][r] = $urandom & reg_mask(r);
            bus_write(s * dma_pkg::STREAM_STRIDE + r * 4, val[s][r]);
        end
    end
    for (int s = 0; s < 4; s++) begin
        for (int r = 0; r < 4; r++) begin
            bus_read(s * dma_pkg::STREAM_STRIDE + r * 4, got);
            check_value($sformatf("%s%0d", reg_name(r), s), got, val[s][r]);
            bus_write(s * dma_pkg::STREAM_STRIDE + r * 4, 32'h0);
        end
    end
endtask

task automatic setup_case(input int c);
    logic [31:0] base;
    logic [31:0] src;
    logic [31:0] cr;
    base = gw(c, F_STREAM) * dma_pkg::STREAM_STRIDE;
    src  = (gw(c, F_DIR) != 0) ? gw(c, F_MAR) : gw(c, F_PAR);
    if (src < 32'h800) begin
        for (int k = 0; k < 4; k++) begin
            mem[(src >> 2) + k] = gw(c, F_SRC + k);
        end
    end
    cr = 32'h1
       | (gw(c, F_DIR)   << dma_pkg::CR_DIR)
       | (gw(c, F_PINC)  << dma_pkg::CR_PINC)
       | (gw(c, F_MINC)  << dma_pkg::CR_MINC)
       | (gw(c, F_CHSEL) << dma_pkg::CR_CHSEL)
       | (gw(c, F_PL)    << dma_pkg::CR_PL)
       | (gw(c, F_TCIE)  << dma_pkg::CR_TCIE)
       | (gw(c, F_TEIE)  << dma_pkg::CR_TEIE);
    bus_write(base + dma_pkg::REG_PAR, gw(c, F_PAR));
    bus_write(base + dma_pkg::REG_MAR, gw(c, F_MAR));
    bus_write(base + dma_pkg::REG_NDTR, gw(c, F_NDTR));
    bus_write(base + dma_pkg::REG_CR, cr);
endtask

task automatic check_case(input int c);
    logic [31:0] got;
    logic [31:0] base;
    logic [31:0] dst;
    logic [31:0] pair;
    logic        tcif;
    logic        teif;
    logic        exp_irq;
    int          s;
    s       = int'(gw(c, F_STREAM));
    base    = s * dma_pkg::STREAM_STRIDE;
    dst     = dest_addr(c);
    pair    = 32'h3 << (2 * s);
    tcif    = ((gw(c, F_ISR) >> (2 * s)) & 32'h1) != 0;
    teif    = ((gw(c, F_ISR) >> (2 * s + 1)) & 32'h1) != 0;
    exp_irq = (tcif && gw(c, F_TCIE) != 0) || (teif && gw(c, F_TEIE) != 0);
    bus_read(32'(dma_pkg::REG_ISR), got);
    check_value($sformatf("ISR bits of stream %0d", s), got & pair, gw(c, F_ISR));
    // counters stay put after an error
    bus_read(base + dma_pkg::REG_NDTR, got);
    check_value($sformatf("NDTR%0d", s), got, teif ? gw(c, F_NDTR) : 32'h0);
    bus_read(base + dma_pkg::REG_CR, got);
    check_value($sformatf("CR%0d en", s), got & 32'h1, 32'h0);
    check_value($sformatf("o_interrupt[%0d]", s), 32'(irq[s]), 32'(exp_irq));
    if (!teif) begin
        for (int k = 0; k < int'(gw(c, F_NDTR)); k++) begin
            check_value($sformatf("mem[%h]", dst + 4 * k), mem[(dst >> 2) + k],
                        gw(c, F_DST + k));
        end
    end
    bus_write(32'(dma_pkg::REG_ISR), gw(c, F_ISR));
    bus_read(32'(dma_pkg::REG_ISR), got);
    check_value($sformatf("ISR bits of stream %0d after clear", s), got & pair, 32'h0);
    check_value($sformatf("o_interrupt[%0d] after clear", s), 32'(irq[s]), 32'h0);
endtask

task automatic run_single(input int c);
    setup_case(c);
    wr_log.delete();
    @(posedge clk);
    req <= 16'h1 << req_bit(c);
    wait_flags(stream_bit(c));
    @(posedge clk);
    req <= '0;
    check_case(c);
endtask

task automatic run_pair(input int a, input int b);
    int first;
    setup_case(a);
    setup_case(b);
    wr_log.delete();
    @(posedge clk);
    req <= (16'h1 << req_bit(a)) | (16'h1 << req_bit(b));
    wait_flags(stream_bit(a) | stream_bit(b));
    @(posedge clk);
    req <= '0;
    first = pick_first(a, b);
    if (wr_log.size() == 0) begin
        $display("No master write was seen for cases %0d and %0d", a, b);
        errors++;
    end else begin
        check_value("m_haddr of first write", wr_log[0], dest_addr(first));
    end
    check_case(a);
    check_case(b);
endtask

initial begin
    logic [31:0] got;
    int          nonsel;
    void'($urandom(SEED));
    clk      = 1'b0;
    rst_n    = 1'b0;
    s_hsel   = 1'b0;
    s_haddr  = 32'h0;
    s_hwrite = 1'b0;
    s_htrans = 2'b00;
    s_hready = 1'b1;
    s_hwdata = 32'h0;
    m_hready = 1'b1;
    m_hresp  = 1'b0;
    m_hrdata = 32'h0;
    req      = '0;
    errors   = 0;
    timeouts = 0;
    $readmemh("testbench/dma_golden.mem", golden);
    // background pattern from each word's byte address
    for (int i = 0; i < 256; i++) begin
        mem[i] = 32'h5a5a0000 | (i << 2);
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    test_registers();
    run_single(0);

    // only a line that chsel does not pick
    setup_case(1);
    nonsel = int'(gw(1, F_STREAM)) * 4 + ((int'(gw(1, F_CHSEL)) + 1) % 4);
    @(posedge clk);
    req <= 16'h1 << nonsel;
    for (int n = 0; n < 24; n++) begin
        @(negedge clk);
        if (m_htrans != 2'b00) begin
            $display("Master started a transfer on a request line that is not selected");
            errors++;
        end
    end
    bus_read(gw(1, F_STREAM) * dma_pkg::STREAM_STRIDE + dma_pkg::REG_NDTR, got);
    check_value("NDTR1 before selected request", got, gw(1, F_NDTR));
    @(posedge clk);
    req <= req | (16'h1 << req_bit(1));
    wait_flags(stream_bit(1));
    @(posedge clk);
    req <= '0;
    check_case(1);

    run_pair(2, 3);
    run_pair(4, 5);

    run_single(6);
    if (wr_log.size() != 0) begin
        $display("Master wrote %0d words although the source read failed", wr_log.size());
        errors++;
    end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== list.f ====
hw/dma_pkg.sv
hw/dma_reg_bus_if.sv
hw/dma_xfer_if.sv
hw/dma_slave_ahb.sv
hw/dma_regs.sv
hw/dma_arbiter.sv
hw/dma_stream_seq.sv
hw/dma_master_ahb.sv
hw/dma_ahb_s4ch4.sv
testbench/tb_dma.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f list.f \
    --top-module tb_dma \
    -o tb_dma

./obj_dir/tb_dma | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

// ==== testbench/dma_golden.mem ====
// case row: stream dir pinc minc pl chsel tcie teie par mar ndtr exp_isr
// data row: four source fill words, then four expected destination words
// case 0, periph to mem, fixed peripheral address
0 0 0 1 1 2 1 0 00000100 00000200 4 00000001
a1b2c3d4 11111111 22222222 33333333 a1b2c3d4 a1b2c3d4 a1b2c3d4 a1b2c3d4
// case 1, mem to periph
1 1 1 1 0 3 1 0 00000300 00000080 3 00000004
0badf00d cafe0001 cafe0002 00000000 0badf00d cafe0001 cafe0002 00000000
// cases 2 and 3, different priority levels
2 0 1 1 1 0 0 0 00000140 00000240 2 00000010
20000001 20000002 00000000 00000000 20000001 20000002 00000000 00000000
3 0 1 1 3 1 1 1 00000160 00000260 2 00000040
30000001 30000002 00000000 00000000 30000001 30000002 00000000 00000000
// cases 4 and 5, equal priority levels
0 1 1 1 2 0 1 0 00000380 00000180 2 00000001
40000001 40000002 00000000 00000000 40000001 40000002 00000000 00000000
2 1 1 1 2 3 0 0 000003a0 000001a0 2 00000010
50000001 50000002 00000000 00000000 50000001 50000002 00000000 00000000
// case 6, source in the error region
1 0 1 1 0 1 0 1 00000800 000002c0 2 00000008
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
